// File: design/commit_pkg.sv
/*
 * Shared widths, exception codes, opcodes and instruction classes for the commit stage.
 * Imported by wildcard in the header of every design unit that needs them.
 */

package commit_pkg;

    // Core widths
    localparam int XLEN           = 32;
    localparam int ILEN           = 32;
    localparam int REG_IDX_LEN    = 5;
    localparam int ROB_EXCEPT_LEN = 4;

    // Default reorder buffer size, overridden from the top level
    localparam int ROB_DEPTH_DEF  = 8;

    // Exception causes, low bits of the RISC-V mcause encoding
    localparam logic [ROB_EXCEPT_LEN-1:0] EXC_INSTR_MISALIGNED = 4'd0;
    localparam logic [ROB_EXCEPT_LEN-1:0] EXC_INSTR_ACCESS     = 4'd1;
    localparam logic [ROB_EXCEPT_LEN-1:0] EXC_ILLEGAL_INSTR    = 4'd2;
    localparam logic [ROB_EXCEPT_LEN-1:0] EXC_BREAKPOINT       = 4'd3;
    localparam logic [ROB_EXCEPT_LEN-1:0] EXC_LOAD_MISALIGNED  = 4'd4;
    localparam logic [ROB_EXCEPT_LEN-1:0] EXC_LOAD_ACCESS      = 4'd5;
    localparam logic [ROB_EXCEPT_LEN-1:0] EXC_STORE_MISALIGNED = 4'd6;
    localparam logic [ROB_EXCEPT_LEN-1:0] EXC_STORE_ACCESS     = 4'd7;
    localparam logic [ROB_EXCEPT_LEN-1:0] EXC_ECALL_M          = 4'd11;

    // Major opcodes, instruction bits [6:0]
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_STORE_FP = 7'b0100111;
    localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
    localparam logic [6:0] OPC_OP_FP    = 7'b1010011;
    localparam logic [6:0] OPC_FMADD    = 7'b1000011;
    localparam logic [6:0] OPC_FMSUB    = 7'b1000111;
    localparam logic [6:0] OPC_FNMSUB   = 7'b1001011;
    localparam logic [6:0] OPC_FNMADD   = 7'b1001111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;

    // What retiring the head instruction does
    typedef enum logic [1:0] {
        CLS_INT_WB = 2'd0,  // writes the integer register file
        CLS_FP_WB  = 2'd1,  // writes the floating-point register file
        CLS_STORE  = 2'd2,  // waits for the store buffer, no writeback
        CLS_NO_WB  = 2'd3   // branches
    } instr_class_t;

endpackage

// File: design/rob_commit_if.sv
/*
 * Head-of-ROB channel towards the commit logic.
 * The ROB side presents the oldest entry, the commit side pops it or flushes.
 */

`timescale 1ns/10ps

interface rob_commit_if import commit_pkg::*; ();

    // Handshake and flush
    logic                       valid;
    logic                       ready;
    logic                       flush;

    // Head entry contents
    logic [ILEN-1:0]            instr;
    logic [XLEN-1:0]            pc;
    logic [REG_IDX_LEN-1:0]     rd_idx;
    logic [XLEN-1:0]            value;
    logic                       except_raised;
    logic [ROB_EXCEPT_LEN-1:0]  except_code;

    modport rob (
        output valid, instr, pc, rd_idx, value, except_raised, except_code,
        input  ready, flush
    );

    modport commit (
        input  valid, instr, pc, rd_idx, value, except_raised, except_code,
        output ready, flush
    );

endinterface

// File: design/commit_decoder.sv
/*
 * Classifies the head instruction by major opcode and says whether it may retire now.
 * Purely combinational, used inside the commit logic.
 */

`timescale 1ns/10ps

module commit_decoder import commit_pkg::*; (
    input  logic [ILEN-1:0]     instruction_i,
    input  logic                sb_store_committing_i,  // store buffer is writing memory
    output instr_class_t        class_o,
    output logic                comm_possible_o
);

    logic [6:0]     opcode;

    assign opcode = instruction_i[6:0];

    // Opcode to class
    always_comb begin
        case (opcode)
            // Integer and FP stores go through the store buffer
            OPC_STORE,
            OPC_STORE_FP: class_o = CLS_STORE;

            // FP loads, FP arithmetic and the fused multiply-add group
            OPC_LOAD_FP,
            OPC_OP_FP,
            OPC_FMADD,
            OPC_FMSUB,
            OPC_FNMSUB,
            OPC_FNMADD:   class_o = CLS_FP_WB;

            // Branches only redirect the PC
            OPC_BRANCH:   class_o = CLS_NO_WB;

            // Everything else lands in the integer file, x0 is filtered there
            default:      class_o = CLS_INT_WB;
        endcase
    end

    // Stores retire only together with the store buffer
    always_comb begin
        if (class_o == CLS_STORE) begin
            comm_possible_o = sb_store_committing_i;
        end else begin
            comm_possible_o = 1'b1;
        end
    end

endmodule

// File: design/rob.sv
/*
 * Circular reorder buffer holding completed instructions in program order.
 * Entries enter through a valid/ready port and leave from the head channel.
 */

`timescale 1ns/10ps

module rob import commit_pkg::*; #(
    parameter int ROB_DEPTH = ROB_DEPTH_DEF
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,

    // Enqueue side, completed instructions
    input  logic                        enq_valid_i,
    output logic                        enq_ready_o,
    input  logic [ILEN-1:0]             enq_instr_i,
    input  logic [XLEN-1:0]             enq_pc_i,
    input  logic [REG_IDX_LEN-1:0]      enq_rd_idx_i,
    input  logic [XLEN-1:0]             enq_value_i,
    input  logic                        enq_except_i,
    input  logic [ROB_EXCEPT_LEN-1:0]   enq_except_code_i,

    // Oldest entry towards commit
    rob_commit_if.rob                   head
);

    localparam int ROB_IDX_LEN = (ROB_DEPTH > 1) ? $clog2(ROB_DEPTH) : 1;

    // Pointers and occupancy
    logic [ROB_IDX_LEN-1:0]     head_ptr;
    logic [ROB_IDX_LEN-1:0]     tail_ptr;
    logic [ROB_IDX_LEN:0]       count;
    logic                       full;
    logic                       empty;
    logic                       enq_fire;
    logic                       pop_fire;

    // Entry storage
    logic [ILEN-1:0]            instr_q [ROB_DEPTH];
    logic [XLEN-1:0]            pc_q [ROB_DEPTH];
    logic [REG_IDX_LEN-1:0]     rd_idx_q [ROB_DEPTH];
    logic [XLEN-1:0]            value_q [ROB_DEPTH];
    logic                       except_q [ROB_DEPTH];
    logic [ROB_EXCEPT_LEN-1:0]  except_code_q [ROB_DEPTH];

    // Wrap at ROB_DEPTH, which need not be a power of two
    function automatic logic [ROB_IDX_LEN-1:0] ptr_next(input logic [ROB_IDX_LEN-1:0] ptr);
        if (ptr == ROB_IDX_LEN'(ROB_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full        = (count == (ROB_IDX_LEN + 1)'(ROB_DEPTH));
    assign empty       = (count == '0);
    assign enq_ready_o = ~full;
    assign enq_fire    = enq_valid_i & ~full;
    assign pop_fire    = head.valid & head.ready;

    // Pointer and count update
    // A flush wins over everything, an entry arriving on the same edge is younger and dropped
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else if (head.flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (enq_fire) begin
                tail_ptr <= ptr_next(tail_ptr);
            end
            if (pop_fire) begin
                head_ptr <= ptr_next(head_ptr);
            end
            case ({enq_fire, pop_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Payload write at the tail, stale slots are never read since count guards them
    always_ff @(posedge clk_i) begin
        if (enq_fire) begin
            instr_q[tail_ptr]       <= enq_instr_i;
            pc_q[tail_ptr]          <= enq_pc_i;
            rd_idx_q[tail_ptr]      <= enq_rd_idx_i;
            value_q[tail_ptr]       <= enq_value_i;
            except_q[tail_ptr]      <= enq_except_i;
            except_code_q[tail_ptr] <= enq_except_code_i;
        end
    end

    // Head entry, stable until it is popped
    assign head.valid         = ~empty;
    assign head.instr         = instr_q[head_ptr];
    assign head.pc            = pc_q[head_ptr];
    assign head.rd_idx        = rd_idx_q[head_ptr];
    assign head.value         = value_q[head_ptr];
    assign head.except_raised = except_q[head_ptr];
    assign head.except_code   = except_code_q[head_ptr];

endmodule

// File: design/commit_logic.sv
/*
 * Retires the ROB head: grants the pop, steers the writeback to the right register
 * file and flushes the ROB on an exception. The commit report is registered.
 */

`timescale 1ns/10ps

module commit_logic import commit_pkg::*; (
    input  logic                        clk_i,
    input  logic                        rst_n_i,

    // ROB head
    rob_commit_if.commit                head,

    // Store buffer status
    input  logic                        sb_store_committing_i,

    // Register file write ports, shared address and data
    output logic                        int_we_o,
    output logic                        fp_we_o,
    output logic [REG_IDX_LEN-1:0]      rf_rd_idx_o,
    output logic [XLEN-1:0]             rf_value_o,

    // Commit report, one cycle after the pop
    output logic                        cm_valid_o,
    output logic [XLEN-1:0]             cm_pc_o,
    output logic                        cm_except_o,
    output logic [ROB_EXCEPT_LEN-1:0]   cm_except_code_o
);

    instr_class_t   cd_class;
    logic           cd_comm_possible;
    logic           pop;
    logic           wb_ok;

    commit_decoder u_comm_decoder (
        .instruction_i          (head.instr),
        .sb_store_committing_i  (sb_store_committing_i),
        .class_o                (cd_class),
        .comm_possible_o        (cd_comm_possible)
    );

    // An exception retires at once, no need to wait for the store buffer
    assign head.ready = head.valid & (head.except_raised | cd_comm_possible);
    assign pop        = head.valid & head.ready;
    assign head.flush = pop & head.except_raised;

    // Writeback only for clean instructions, on the pop edge
    assign wb_ok    = pop & ~head.except_raised;
    assign int_we_o = wb_ok & (cd_class == CLS_INT_WB);
    assign fp_we_o  = wb_ok & (cd_class == CLS_FP_WB);

    assign rf_rd_idx_o = head.rd_idx;
    assign rf_value_o  = head.value;

    // Report control
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cm_valid_o       <= 1'b0;
            cm_except_o      <= 1'b0;
            cm_except_code_o <= '0;
        end else begin
            cm_valid_o  <= pop;
            cm_except_o <= head.flush;
            if (pop) begin
                cm_except_code_o <= head.except_raised ? head.except_code : '0;
            end
        end
    end

    // Retired PC, only meaningful with cm_valid_o
    always_ff @(posedge clk_i) begin
        if (pop) begin
            cm_pc_o <= head.pc;
        end
    end

endmodule

// File: design/regfile.sv
/*
 * Architectural register file with one write and one combinational read port.
 * ZERO_REG=1 gives the integer file its hardwired x0, 0 leaves f0 writable.
 */

`timescale 1ns/10ps

module regfile import commit_pkg::*; #(
    parameter int ZERO_REG = 1
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,

    // Write port
    input  logic                        we_i,
    input  logic [REG_IDX_LEN-1:0]      waddr_i,
    input  logic [XLEN-1:0]             wdata_i,

    // Read port
    input  logic [REG_IDX_LEN-1:0]      raddr_i,
    output logic [XLEN-1:0]             rdata_o
);

    localparam int NUM_REGS = 2 ** REG_IDX_LEN;

    logic [XLEN-1:0]    regs [NUM_REGS];
    logic               wr_en;

    // Writes to entry zero vanish in the integer flavour
    assign wr_en = we_i & ~((ZERO_REG != 0) && (waddr_i == '0));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Entry zero stays at its reset value, so no read-side masking is needed
    assign rdata_o = regs[raddr_i];

endmodule

// File: design/commit_unit_top.sv
/*
 * Retirement end of the core: ROB, commit logic and the integer and FP register files.
 * Completed instructions enter on the enqueue port, retirements leave on the cm_* report.
 */

`timescale 1ns/10ps

module commit_unit_top import commit_pkg::*; #(
    parameter int ROB_DEPTH = ROB_DEPTH_DEF
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,

    // Enqueue of completed instructions
    input  logic                        enq_valid_i,
    output logic                        enq_ready_o,
    input  logic [ILEN-1:0]             enq_instr_i,
    input  logic [XLEN-1:0]             enq_pc_i,
    input  logic [REG_IDX_LEN-1:0]      enq_rd_idx_i,
    input  logic [XLEN-1:0]             enq_value_i,
    input  logic                        enq_except_i,
    input  logic [ROB_EXCEPT_LEN-1:0]   enq_except_code_i,

    // Store buffer
    input  logic                        sb_store_committing_i,

    // Register file read ports
    input  logic [REG_IDX_LEN-1:0]      int_raddr_i,
    output logic [XLEN-1:0]             int_rdata_o,
    input  logic [REG_IDX_LEN-1:0]      fp_raddr_i,
    output logic [XLEN-1:0]             fp_rdata_o,

    // Commit report
    output logic                        cm_valid_o,
    output logic [XLEN-1:0]             cm_pc_o,
    output logic                        cm_except_o,
    output logic [ROB_EXCEPT_LEN-1:0]   cm_except_code_o
);

    logic                       int_we;
    logic                       fp_we;
    logic [REG_IDX_LEN-1:0]     rf_rd_idx;
    logic [XLEN-1:0]            rf_value;

    rob_commit_if u_head_if ();

    rob #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_rob (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .enq_valid_i       (enq_valid_i),
        .enq_ready_o       (enq_ready_o),
        .enq_instr_i       (enq_instr_i),
        .enq_pc_i          (enq_pc_i),
        .enq_rd_idx_i      (enq_rd_idx_i),
        .enq_value_i       (enq_value_i),
        .enq_except_i      (enq_except_i),
        .enq_except_code_i (enq_except_code_i),
        .head              (u_head_if.rob)
    );

    commit_logic u_commit (
        .clk_i                 (clk_i),
        .rst_n_i               (rst_n_i),
        .head                  (u_head_if.commit),
        .sb_store_committing_i (sb_store_committing_i),
        .int_we_o              (int_we),
        .fp_we_o               (fp_we),
        .rf_rd_idx_o           (rf_rd_idx),
        .rf_value_o            (rf_value),
        .cm_valid_o            (cm_valid_o),
        .cm_pc_o               (cm_pc_o),
        .cm_except_o           (cm_except_o),
        .cm_except_code_o      (cm_except_code_o)
    );

    // Integer file, x0 hardwired
    regfile #(
        .ZERO_REG (1)
    ) u_int_rf (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .we_i    (int_we),
        .waddr_i (rf_rd_idx),
        .wdata_i (rf_value),
        .raddr_i (int_raddr_i),
        .rdata_o (int_rdata_o)
    );

    // FP file, f0 is an ordinary register
    regfile #(
        .ZERO_REG (0)
    ) u_fp_rf (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .we_i    (fp_we),
        .waddr_i (rf_rd_idx),
        .wdata_i (rf_value),
        .raddr_i (fp_raddr_i),
        .rdata_o (fp_rdata_o)
    );

endmodule

// File: verif/commit_unit_chk.sv
/*
 * Assertions on the commit handshake and writeback steering.
 * Attached to every commit_logic instance by the bind at the end of this file.
 */

`timescale 1ns/10ps

module commit_unit_chk import commit_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                valid_i,
    input  logic                ready_i,
    input  logic                except_i,
    input  logic [ILEN-1:0]     instr_i,
    input  logic                sb_i,
    input  logic                int_we_i,
    input  logic                fp_we_i
);

    logic   is_store;
    logic   is_fp;

    // Integer and FP stores both wait for the store buffer
    assign is_store = (instr_i[6:0] == OPC_STORE) || (instr_i[6:0] == OPC_STORE_FP);

    // FP loads, FP arithmetic and the fused multiply-add group
    assign is_fp = instr_i[6:0] inside {OPC_LOAD_FP, OPC_OP_FP, OPC_FMADD,
                                        OPC_FMSUB, OPC_FNMSUB, OPC_FNMADD};

    // Each write lands only in the register file that the opcode selects
    a_rf_steer: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(int_we_i && (is_fp || is_store)) && !(fp_we_i && !is_fp))
        else $error("register write steered to the wrong register file");

    // Exception at the head retires without writeback
    a_no_wb_on_exc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (valid_i && except_i) |-> !(int_we_i || fp_we_i))
        else $error("register write while an exception entry is at the head");

    // A clean store leaves only together with the store buffer
    a_store_waits_sb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (valid_i && ready_i && is_store && !except_i) |-> sb_i)
        else $error("store popped while the store buffer was not committing");

endmodule

bind commit_logic commit_unit_chk u_commit_chk (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .valid_i  (head.valid),
    .ready_i  (head.ready),
    .except_i (head.except_raised),
    .instr_i  (head.instr),
    .sb_i     (sb_store_committing_i),
    .int_we_i (int_we_o),
    .fp_we_i  (fp_we_o)
);

// File: verif/tb_commit_unit.sv
/*
 * Testbench for the commit unit. Reads sections of completed instructions from the
 * test data file, enqueues them, and checks the commit stream and both register files.
 */

`timescale 1ns/10ps

module tb_commit_unit import commit_pkg::*; ();

    localparam int    TB_ROB_DEPTH = 4;
    localparam int    WAIT_LIMIT   = 400;
    localparam int    NUM_REGS     = 32;
    localparam string DATA_FILE    = "verif/commit_testdata.txt";

    // DUT connections
    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       enq_valid;
    logic                       enq_ready;
    logic [ILEN-1:0]            enq_instr;
    logic [XLEN-1:0]            enq_pc;
    logic [REG_IDX_LEN-1:0]     enq_rd_idx;
    logic [XLEN-1:0]            enq_value;
    logic                       enq_except;
    logic [ROB_EXCEPT_LEN-1:0]  enq_except_code;
    logic                       sb_commit = 1'b0;
    logic [REG_IDX_LEN-1:0]     int_raddr;
    logic [XLEN-1:0]            int_rdata;
    logic [REG_IDX_LEN-1:0]     fp_raddr;
    logic [XLEN-1:0]            fp_rdata;
    logic                       cm_valid;
    logic [XLEN-1:0]            cm_pc;
    logic                       cm_except;
    logic [ROB_EXCEPT_LEN-1:0]  cm_except_code;

    // Current section with one queue per data column
    string                      test_name;
    int                         hold_mode;
    logic [ILEN-1:0]            sec_instr [$];
    logic [XLEN-1:0]            sec_pc [$];
    logic [REG_IDX_LEN-1:0]     sec_rd [$];
    logic [XLEN-1:0]            sec_value [$];
    logic                       sec_except [$];
    logic [ROB_EXCEPT_LEN-1:0]  sec_code [$];
    string                      sec_class [$];
    int                         exp_idx [$];

    // Expected architectural state
    logic [XLEN-1:0]            int_model [NUM_REGS];
    logic [XLEN-1:0]            fp_model [NUM_REGS];

    // Store buffer control and run status
    logic                       sb_random;
    logic                       hold_sb;
    logic                       saw_full;
    logic                       run_passed;
    logic                       fail_reported;

    // File parsing
    int                         fd;
    int                         n;
    string                      tok;
    logic [8*160-1:0]           rest;
    logic [ILEN-1:0]            f_instr;
    logic [XLEN-1:0]            f_pc;
    logic [REG_IDX_LEN-1:0]     f_rd;
    logic [XLEN-1:0]            f_value;
    logic                       f_exc;
    logic [ROB_EXCEPT_LEN-1:0]  f_code;
    string                      f_class;

    commit_unit_top #(
        .ROB_DEPTH (TB_ROB_DEPTH)
    ) dut0 (
        .clk_i                 (clk),
        .rst_n_i               (rst_n),
        .enq_valid_i           (enq_valid),
        .enq_ready_o           (enq_ready),
        .enq_instr_i           (enq_instr),
        .enq_pc_i              (enq_pc),
        .enq_rd_idx_i          (enq_rd_idx),
        .enq_value_i           (enq_value),
        .enq_except_i          (enq_except),
        .enq_except_code_i     (enq_except_code),
        .sb_store_committing_i (sb_commit),
        .int_raddr_i           (int_raddr),
        .int_rdata_o           (int_rdata),
        .fp_raddr_i            (fp_raddr),
        .fp_rdata_o            (fp_rdata),
        .cm_valid_o            (cm_valid),
        .cm_pc_o               (cm_pc),
        .cm_except_o           (cm_except),
        .cm_except_code_o      (cm_except_code)
    );

    always #2 clk = ~clk;

    // Store buffer is held low, drops low at random or keeps committing
    always @(negedge clk) begin
        if (hold_sb) begin
            sb_commit = 1'b0;
        end else if (sb_random) begin
            sb_commit = (($urandom % 4) != 0);
        end else begin
            sb_commit = 1'b1;
        end
    end

    task fail_now(input string msg);
        $display("%s", msg);
        fail_reported = 1'b1;
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task check_commit(input logic [XLEN-1:0] exp_pc, input logic exp_exc,
                      input logic [ROB_EXCEPT_LEN-1:0] exp_code,
                      input logic [XLEN-1:0] act_pc, input logic act_exc,
                      input logic [ROB_EXCEPT_LEN-1:0] act_code);
        // Code only carries meaning on an exception
        if (act_pc !== exp_pc || act_exc !== exp_exc || (exp_exc && act_code !== exp_code)) begin
            fail_now($sformatf("error %s: commit expected pc %h exc %b code %h %s",
                               test_name, exp_pc, exp_exc, exp_code,
                               $sformatf("actual pc %h exc %b code %h",
                                         act_pc, act_exc, act_code)));
        end
    endtask

    task check_reg(input string what, input logic [XLEN-1:0] exp_val,
                   input logic [XLEN-1:0] act_val);
        if (act_val !== exp_val) begin
            fail_now($sformatf("error %s: %s expected %h actual %h",
                               test_name, what, exp_val, act_val));
        end
    endtask

    // Commit stream follows the section order and stops at the first exception
    task build_expected();
        exp_idx.delete();
        for (int i = 0; i < sec_pc.size(); i++) begin
            exp_idx.push_back(i);
            if (sec_except[i]) begin
                break;
            end
            if (sec_class[i] == "int") begin
                // x0 keeps reading zero
                if (sec_rd[i] != '0) begin
                    int_model[sec_rd[i]] = sec_value[i];
                end
            end else if (sec_class[i] == "fp") begin
                fp_model[sec_rd[i]] = sec_value[i];
            end else if (sec_class[i] != "st" && sec_class[i] != "br") begin
                fail_now($sformatf("unknown class tag %s in the test data", sec_class[i]));
            end
        end
    endtask

    task enqueue_entry(input int i);
        int waited;
        enq_valid       = 1'b1;
        enq_instr       = sec_instr[i];
        enq_pc          = sec_pc[i];
        enq_rd_idx      = sec_rd[i];
        enq_value       = sec_value[i];
        enq_except      = sec_except[i];
        enq_except_code = sec_code[i];
        waited = 0;
        while (!enq_ready) begin
            // ROB is full behind the held store so the store buffer is released
            if (hold_sb) begin
                saw_full = 1'b1;
                hold_sb  = 1'b0;
            end
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_now("timeout waiting for the ROB to accept an entry");
            end
        end
        // Accepted on the rising edge in between
        @(negedge clk);
        enq_valid = 1'b0;
    endtask

    task enqueue_section();
        for (int i = 0; i < sec_pc.size(); i++) begin
            if (hold_mode == 0) begin
                repeat ($urandom % 4) @(negedge clk);
            end
            enqueue_entry(i);
        end
        hold_sb = 1'b0;
    endtask

    task collect_commits();
        int k;
        int waited;
        k = 0;
        waited = 0;
        while (k < exp_idx.size()) begin
            @(negedge clk);
            if (cm_valid) begin
                check_commit(sec_pc[exp_idx[k]], sec_except[exp_idx[k]], sec_code[exp_idx[k]],
                             cm_pc, cm_except, cm_except_code);
                k++;
                waited = 0;
            end else begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    fail_now("timeout waiting for a commit report");
                end
            end
        end
    endtask

    task check_regfiles();
        for (int r = 0; r < NUM_REGS; r++) begin
            @(negedge clk);
            int_raddr = REG_IDX_LEN'(r);
            fp_raddr  = REG_IDX_LEN'(r);
            @(posedge clk);
            check_reg($sformatf("x%0d", r), int_model[r], int_rdata);
            check_reg($sformatf("f%0d", r), fp_model[r], fp_rdata);
        end
    endtask

    task run_section();
        build_expected();
        saw_full  = 1'b0;
        hold_sb   = (hold_mode != 0);
        sb_random = (hold_mode == 0);
        repeat (2) @(negedge clk);
        fork
            enqueue_section();
            collect_commits();
        join
        sb_random = 1'b0;
        hold_sb   = 1'b0;
        if (hold_mode != 0 && sec_pc.size() > TB_ROB_DEPTH && !saw_full) begin
            fail_now($sformatf("ROB never became full in section %s", test_name));
        end
        // Flushed or stray entries must stay silent
        for (int c = 0; c < 8; c++) begin
            @(negedge clk);
            if (cm_valid) begin
                fail_now($sformatf("unexpected extra commit at pc %h in section %s",
                                   cm_pc, test_name));
            end
        end
        check_regfiles();
    endtask

    initial begin
        rst_n           = 1'b0;
        enq_valid       = 1'b0;
        enq_instr       = '0;
        enq_pc          = '0;
        enq_rd_idx      = '0;
        enq_value       = '0;
        enq_except      = 1'b0;
        enq_except_code = '0;
        int_raddr       = '0;
        fp_raddr        = '0;
        sb_random       = 1'b0;
        hold_sb         = 1'b0;
        run_passed      = 1'b0;
        fail_reported   = 1'b0;
        void'($urandom(79756));
        for (int r = 0; r < NUM_REGS; r++) begin
            int_model[r] = '0;
            fp_model[r]  = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (!enq_ready || cm_valid || cm_except) begin
            fail_now("ROB not ready or commit report active after reset");
        end
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            fail_now("cannot open the test data file");
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                void'($fgets(rest, fd));
            end else if (tok == "section") begin
                n = $fscanf(fd, "%s %d", test_name, hold_mode);
                sec_instr.delete();
                sec_pc.delete();
                sec_rd.delete();
                sec_value.delete();
                sec_except.delete();
                sec_code.delete();
                sec_class.delete();
            end else if (tok == "entry") begin
                n = $fscanf(fd, "%h %h %h %h %h %h %s",
                            f_instr, f_pc, f_rd, f_value, f_exc, f_code, f_class);
                if (n != 7) begin
                    fail_now("malformed entry line in the test data");
                end
                sec_instr.push_back(f_instr);
                sec_pc.push_back(f_pc);
                sec_rd.push_back(f_rd);
                sec_value.push_back(f_value);
                sec_except.push_back(f_exc);
                sec_code.push_back(f_code);
                sec_class.push_back(f_class);
            end else if (tok == "end") begin
                run_section();
            end else begin
                fail_now($sformatf("unknown keyword %s in the test data", tok));
            end
        end
        $fclose(fd);
        run_passed = 1'b1;
        $display("TEST OK");
        $finish;
    end

    final begin
        if (!run_passed && !fail_reported) begin
            $display("TEST FAILED");
        end
    end

endmodule

// File: verif/commit_testdata.txt
# entry: instr pc rd value except code class, hex fields, class is int, fp, st or br
# section: name hold, hold 1 keeps the store buffer low until the ROB fills or all entries are in
# an exception section starts with a store and fits in the ROB
section int_fp_mix 0
entry 00a00093 00000100 01 0000000a 0 0 int
entry 00000013 00000104 00 deadbeef 0 0 int
entry 00207053 00000108 00 3f800000 0 0 fp
entry 0000a287 0000010c 05 40490fdb 0 0 fp
entry 0020a423 00000110 02 0badf00d 0 0 st
entry 00208463 00000114 03 0badcafe 0 0 br
entry 1820f343 00000118 06 c0a00000 0 0 fp
end
section rob_full 1
entry 0030a023 00000200 07 11111111 0 0 st
entry 00308233 00000204 04 00000044 0 0 int
entry 0030f3cb 00000208 07 bf800000 0 0 fp
entry 0000a427 0000020c 08 22222222 0 0 st
entry 000014b7 00000210 09 00001000 0 0 int
entry 0030f54f 00000214 0a 3e800000 0 0 fp
end
section exception_flush 1
entry 0040a023 00000300 0b 33333333 0 0 st
entry 00408593 00000304 0b 000000bb 0 0 int
entry 00000073 00000308 0c 0000cccc 1 b int
entry 00408613 0000030c 0c 000000dd 0 0 int
end
section after_flush 0
entry 00508613 00000400 0c 000000ee 0 0 int
entry 00a0f6c7 00000404 0d 41200000 0 0 fp
end

// File: verilog.f
design/commit_pkg.sv
design/rob_commit_if.sv
design/commit_decoder.sv
design/rob.sv
design/commit_logic.sv
design/regfile.sv
design/commit_unit_top.sv
verif/commit_unit_chk.sv
verif/tb_commit_unit.sv

// File: Makefile
# Verilator build and run for the commit unit testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_commit_unit
FILELIST  := verilog.f
BUILD     := obj_dir
LOG       := sim.log
PASS_MSG  := TEST OK

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

sim: build
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD) $(LOG)
